// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
RTL_TOP   ?= mips_lite_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
logic/mips_isa_pkg.sv
logic/core_pkg.sv
logic/fetch_sequencer.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/result_writeback.sv
logic/mips_lite_core.sv
test/tb_imem.sv
test/tb_core.sv

// File: logic/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
	input  core_pkg::alu_op_e alu_op_i,
	input  core_pkg::word_t   op_a_i,
	input  core_pkg::word_t   op_b_i,
	output core_pkg::word_t   logic_o,
	output core_pkg::word_t   shift_o,
	output core_pkg::word_t   arith_o
);
	import core_pkg::*;

	logic [4:0] sa;
	word_t      sum;
	word_t      diff;
	logic       lt_s;
	logic       lt_u;

	assign sa   = op_a_i[4:0]; // shamt field or rs, low bits only
	assign sum  = op_a_i + op_b_i;
	assign diff = op_a_i - op_b_i;
	assign lt_s = $signed(op_a_i) < $signed(op_b_i);
	assign lt_u = op_a_i < op_b_i;

	always_comb begin
		case (alu_op_i)
			ALU_AND: logic_o = op_a_i & op_b_i;
			ALU_OR:  logic_o = op_a_i | op_b_i;
			ALU_XOR: logic_o = op_a_i ^ op_b_i;
			ALU_NOR: logic_o = ~(op_a_i | op_b_i);
			default: logic_o = '0;
		endcase
	end

	always_comb begin
		case (alu_op_i)
			ALU_SLL: shift_o = op_b_i << sa;
			ALU_SRL: shift_o = op_b_i >> sa;
			ALU_SRA: shift_o = $signed(op_b_i) >>> sa;
			default: shift_o = '0;
		endcase
	end

	always_comb begin
		case (alu_op_i)
			ALU_SUB:  arith_o = diff;
			ALU_SLT:  arith_o = {31'd0, lt_s};
			ALU_SLTU: arith_o = {31'd0, lt_u};
			default:  arith_o = sum; // addu, addiu
		endcase
	end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_LINK // result comes from the link address
	} alu_op_e;

	typedef enum logic [2:0] {
		RES_LOGIC,
		RES_SHIFT,
		RES_ARITH,
		RES_LINK,
		RES_NONE
	} res_sel_e;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		WRITE
	} seq_state_e;

endpackage

`default_nettype wire

// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst_i,
	output logic            wb_cyc_o,
	output logic            wb_stb_o,
	output core_pkg::word_t wb_adr_o,
	input  core_pkg::word_t wb_dat_i,
	input  logic            wb_ack_i,
	input  logic            branch_take_i,
	input  core_pkg::word_t branch_target_i,
	output core_pkg::word_t instr_o,
	output core_pkg::word_t pc_o,
	output logic            exec_en_o
);
	import core_pkg::*;

	seq_state_e state_q;
	word_t      pc_q;
	word_t      instr_q;
	word_t      br_target_q;
	logic       req_q;
	logic       br_armed_q; // branch taken, delay slot not fetched yet
	logic       br_slot_q;  // delay slot is the instruction in flight
	logic       fetch_done;
	logic       br_capture;

	assign fetch_done = req_q & wb_ack_i;
	// a branch sitting in a delay slot is not followed
	assign br_capture = exec_en_o & branch_take_i & ~br_slot_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= FETCH;
			pc_q       <= RESET_PC;
			req_q      <= 1'b0;
			br_armed_q <= 1'b0;
			br_slot_q  <= 1'b0;
		end else begin
			case (state_q)
				FETCH: begin
					req_q <= ~fetch_done; // also raises the first request after reset
					if (fetch_done) begin
						state_q <= EXEC;
					end
				end
				EXEC: begin
					state_q <= WRITE;
					if (br_capture) begin
						br_armed_q <= 1'b1;
					end
				end
				WRITE: begin
					state_q    <= FETCH;
					req_q      <= 1'b1;
					br_armed_q <= 1'b0;
					br_slot_q  <= br_armed_q;
					pc_q       <= br_slot_q ? br_target_q : pc_q + 32'd4;
				end
				default: state_q <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done) begin
			instr_q <= wb_dat_i;
		end
		if (br_capture) begin
			br_target_q <= branch_target_i;
		end
	end

	assign wb_cyc_o  = req_q;
	assign wb_stb_o  = req_q;
	assign wb_adr_o  = pc_q;
	assign instr_o   = instr_q;
	assign pc_o      = pc_q;
	assign exec_en_o = (state_q == EXEC);

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  core_pkg::word_t     instr_i,
	input  core_pkg::word_t     pc_i,
	output core_pkg::reg_addr_t rs_addr_o,
	output core_pkg::reg_addr_t rt_addr_o,
	input  core_pkg::word_t     rs_data_i,
	input  core_pkg::word_t     rt_data_i,
	output core_pkg::alu_op_e   alu_op_o,
	output core_pkg::res_sel_e  res_sel_o,
	output core_pkg::word_t     op_a_o,
	output core_pkg::word_t     op_b_o,
	output core_pkg::word_t     link_o,
	output core_pkg::reg_addr_t dest_o,
	output logic                wreg_o,
	output logic                invalid_o,
	output logic                branch_take_o,
	output core_pkg::word_t     branch_target_o
);
	import core_pkg::*;
	import mips_isa_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rd;
	reg_addr_t  shamt;
	word_t      imm_zx;
	word_t      imm_sx;
	word_t      imm_hi;
	word_t      shamt_w;
	word_t      pc_plus4;
	word_t      rel_target;
	word_t      abs_target;
	logic       rs_zero;
	logic       rs_neg;
	alu_op_e    fn_op;

	assign opcode    = instr_i[OP_POS +: 6];
	assign funct     = instr_i[5:0];
	assign rs_addr_o = instr_i[RS_POS +: 5];
	assign rt_addr_o = instr_i[RT_POS +: 5];
	assign rd        = instr_i[RD_POS +: 5];
	assign shamt     = instr_i[SHAMT_POS +: 5];

	assign imm_zx  = {16'h0000, instr_i[15:0]};
	assign imm_sx  = {{16{instr_i[15]}}, instr_i[15:0]};
	assign imm_hi  = {instr_i[15:0], 16'h0000}; // lui
	assign shamt_w = {27'd0, shamt};

	assign pc_plus4   = pc_i + 32'd4;
	assign rel_target = pc_plus4 + {imm_sx[29:0], 2'b00};
	assign abs_target = {pc_plus4[31:28], instr_i[25:0], 2'b00};
	assign link_o     = pc_i + 32'd8; // skips the delay slot

	assign rs_zero = (rs_data_i == '0);
	assign rs_neg  = rs_data_i[31];

	// ALU operation for register-type instructions
	always_comb begin
		case (funct)
			FN_SLL, FN_SLLV: fn_op = ALU_SLL;
			FN_SRL, FN_SRLV: fn_op = ALU_SRL;
			FN_SRA, FN_SRAV: fn_op = ALU_SRA;
			FN_AND:          fn_op = ALU_AND;
			FN_OR:           fn_op = ALU_OR;
			FN_XOR:          fn_op = ALU_XOR;
			FN_NOR:          fn_op = ALU_NOR;
			FN_SUBU:         fn_op = ALU_SUB;
			FN_SLT:          fn_op = ALU_SLT;
			FN_SLTU:         fn_op = ALU_SLTU;
			FN_JALR:         fn_op = ALU_LINK;
			default:         fn_op = ALU_ADD;
		endcase
	end

	always_comb begin
		alu_op_o        = ALU_ADD;
		res_sel_o       = RES_NONE;
		op_a_o          = rs_data_i;
		op_b_o          = rt_data_i;
		dest_o          = rd;
		wreg_o          = 1'b0;
		invalid_o       = 1'b0;
		branch_take_o   = 1'b0;
		branch_target_o = rel_target;
		case (opcode)
			OP_SPECIAL: begin
				alu_op_o = fn_op;
				wreg_o   = 1'b1;
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						res_sel_o = RES_SHIFT;
						op_a_o    = shamt_w;
					end
					FN_SLLV, FN_SRLV, FN_SRAV: res_sel_o = RES_SHIFT;
					FN_AND, FN_OR, FN_XOR, FN_NOR: res_sel_o = RES_LOGIC;
					FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU: res_sel_o = RES_ARITH;
					FN_JR: begin
						wreg_o          = 1'b0;
						branch_take_o   = 1'b1;
						branch_target_o = rs_data_i;
					end
					FN_JALR: begin
						res_sel_o       = RES_LINK;
						branch_take_o   = 1'b1;
						branch_target_o = rs_data_i;
					end
					default: begin
						wreg_o    = 1'b0;
						invalid_o = 1'b1;
					end
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				wreg_o    = 1'b1;
				dest_o    = rt_addr_o;
				res_sel_o = RES_LOGIC;
				op_b_o    = imm_zx;
				alu_op_o  = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_LUI: begin
				wreg_o    = 1'b1;
				dest_o    = rt_addr_o;
				res_sel_o = RES_LOGIC;
				alu_op_o  = ALU_OR;
				op_a_o    = '0;
				op_b_o    = imm_hi;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				wreg_o    = 1'b1;
				dest_o    = rt_addr_o;
				res_sel_o = RES_ARITH;
				op_b_o    = imm_sx; // sltiu compares against the sign-extended value
				alu_op_o  = (opcode == OP_ADDIU) ? ALU_ADD :
					(opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			OP_J: begin
				branch_take_o   = 1'b1;
				branch_target_o = abs_target;
			end
			OP_JAL: begin
				wreg_o          = 1'b1;
				dest_o          = LINK_REG;
				res_sel_o       = RES_LINK;
				alu_op_o        = ALU_LINK;
				branch_take_o   = 1'b1;
				branch_target_o = abs_target;
			end
			OP_BEQ:  branch_take_o = (rs_data_i == rt_data_i);
			OP_BNE:  branch_take_o = (rs_data_i != rt_data_i);
			OP_BLEZ: branch_take_o = rs_neg | rs_zero;
			OP_BGTZ: branch_take_o = ~rs_neg & ~rs_zero;
			OP_REGIMM: begin
				case (rt_addr_o)
					RT_BLTZ: branch_take_o = rs_neg;
					RT_BGEZ: branch_take_o = ~rs_neg;
					default: invalid_o = 1'b1;
				endcase
			end
			default: invalid_o = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// field positions in the instruction word
	localparam int OP_POS    = 26;
	localparam int RS_POS    = 21;
	localparam int RT_POS    = 16;
	localparam int RD_POS    = 11;
	localparam int SHAMT_POS = 6;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01; // rt selects the branch
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// funct codes under SPECIAL
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	localparam logic [4:0] RT_BLTZ  = 5'h00;
	localparam logic [4:0] RT_BGEZ  = 5'h01;
	localparam logic [4:0] LINK_REG = 5'd31; // jal return address

endpackage

`default_nettype wire

// File: logic/mips_lite_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_lite_core #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                clk,
	input  logic                rst_i,
	output logic                wb_cyc_o,
	output logic                wb_stb_o,
	output core_pkg::word_t     wb_adr_o,
	input  core_pkg::word_t     wb_dat_i,
	input  logic                wb_ack_i,
	output logic                retire_o,
	output logic                rd_we_o,
	output logic                illegal_o,
	output core_pkg::reg_addr_t rd_addr_o,
	output core_pkg::word_t     rd_data_o
);
	import core_pkg::*;

	word_t     instr;
	word_t     pc;
	logic      exec_en;
	logic      branch_take;
	word_t     branch_target;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_data;
	word_t     rt_data;
	alu_op_e   alu_op;
	res_sel_e  res_sel;
	word_t     op_a;
	word_t     op_b;
	word_t     link;
	reg_addr_t dest;
	logic      wreg;
	logic      invalid;
	word_t     logic_res;
	word_t     shift_res;
	word_t     arith_res;

	fetch_sequencer #(
		.RESET_PC(RESET_PC)
	) u_fetch_sequencer (
		.clk             (clk),
		.rst_i           (rst_i),
		.wb_cyc_o        (wb_cyc_o),
		.wb_stb_o        (wb_stb_o),
		.wb_adr_o        (wb_adr_o),
		.wb_dat_i        (wb_dat_i),
		.wb_ack_i        (wb_ack_i),
		.branch_take_i   (branch_take),
		.branch_target_i (branch_target),
		.instr_o         (instr),
		.pc_o            (pc),
		.exec_en_o       (exec_en)
	);

	instr_decode u_instr_decode (
		.instr_i         (instr),
		.pc_i            (pc),
		.rs_addr_o       (rs_addr),
		.rt_addr_o       (rt_addr),
		.rs_data_i       (rs_data),
		.rt_data_i       (rt_data),
		.alu_op_o        (alu_op),
		.res_sel_o       (res_sel),
		.op_a_o          (op_a),
		.op_b_o          (op_b),
		.link_o          (link),
		.dest_o          (dest),
		.wreg_o          (wreg),
		.invalid_o       (invalid),
		.branch_take_o   (branch_take),
		.branch_target_o (branch_target)
	);

	// written from the retire outputs in the WRITE cycle
	reg_file u_reg_file (
		.clk       (clk),
		.rst_i     (rst_i),
		.ra_addr_i (rs_addr),
		.rb_addr_i (rt_addr),
		.ra_data_o (rs_data),
		.rb_data_o (rt_data),
		.we_i      (rd_we_o),
		.wa_addr_i (rd_addr_o),
		.wd_i      (rd_data_o)
	);

	alu_execute u_alu_execute (
		.alu_op_i (alu_op),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.logic_o  (logic_res),
		.shift_o  (shift_res),
		.arith_o  (arith_res)
	);

	result_writeback u_result_writeback (
		.clk       (clk),
		.rst_i     (rst_i),
		.exec_en_i (exec_en),
		.res_sel_i (res_sel),
		.logic_i   (logic_res),
		.shift_i   (shift_res),
		.arith_i   (arith_res),
		.link_i    (link),
		.dest_i    (dest),
		.wreg_i    (wreg),
		.invalid_i (invalid),
		.retire_o  (retire_o),
		.rd_we_o   (rd_we_o),
		.illegal_o (illegal_o),
		.rd_addr_o (rd_addr_o),
		.rd_data_o (rd_data_o)
	);

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                rst_i,
	input  core_pkg::reg_addr_t ra_addr_i,
	input  core_pkg::reg_addr_t rb_addr_i,
	output core_pkg::word_t     ra_data_o,
	output core_pkg::word_t     rb_data_o,
	input  logic                we_i,
	input  core_pkg::reg_addr_t wa_addr_i,
	input  core_pkg::word_t     wd_i
);
	import core_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && wa_addr_i != '0) begin // r0 writes dropped
			regs[wa_addr_i] <= wd_i;
		end
	end

	assign ra_data_o = (ra_addr_i == '0) ? '0 : regs[ra_addr_i];
	assign rb_data_o = (rb_addr_i == '0) ? '0 : regs[rb_addr_i];

endmodule

`default_nettype wire

// File: logic/result_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                exec_en_i,
	input  core_pkg::res_sel_e  res_sel_i,
	input  core_pkg::word_t     logic_i,
	input  core_pkg::word_t     shift_i,
	input  core_pkg::word_t     arith_i,
	input  core_pkg::word_t     link_i,
	input  core_pkg::reg_addr_t dest_i,
	input  logic                wreg_i,
	input  logic                invalid_i,
	output logic                retire_o,
	output logic                rd_we_o,
	output logic                illegal_o,
	output core_pkg::reg_addr_t rd_addr_o,
	output core_pkg::word_t     rd_data_o
);
	import core_pkg::*;

	word_t     result;
	word_t     data_q;
	reg_addr_t dest_q;
	logic      retire_q;
	logic      we_q;
	logic      illegal_q;

	always_comb begin
		case (res_sel_i)
			RES_LOGIC: result = logic_i;
			RES_SHIFT: result = shift_i;
			RES_ARITH: result = arith_i;
			RES_LINK:  result = link_i;
			default:   result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			retire_q  <= 1'b0;
			we_q      <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			retire_q  <= exec_en_i;
			we_q      <= exec_en_i & wreg_i & ~invalid_i;
			illegal_q <= exec_en_i & invalid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (exec_en_i) begin
			data_q <= result;
			dest_q <= dest_i;
		end
	end

	assign retire_o  = retire_q;
	assign rd_we_o   = we_q; // also the register file write enable
	assign illegal_o = illegal_q;
	assign rd_addr_o = dest_q;
	assign rd_data_o = data_q;

endmodule

`default_nettype wire

// File: test/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
	import core_pkg::*;
	import mips_isa_pkg::*;

	localparam word_t RESET_PC = 32'h0000_0040;

	logic      clk;
	logic      rst_i;
	logic      wb_cyc_o;
	logic      wb_stb_o;
	word_t     wb_adr_o;
	word_t     wb_dat_i;
	logic      wb_ack_i;
	logic      retire_o;
	logic      rd_we_o;
	logic      illegal_o;
	reg_addr_t rd_addr_o;
	word_t     rd_data_o;
	int        prog_len;

	word_t mregs [32];
	word_t exp_pc;
	word_t end_pc;
	word_t cur_instr;
	word_t cur_pc;
	word_t saved_tgt;
	word_t held_adr;
	logic  slot_active;
	logic  in_flight;
	logic  held_valid;
	logic  rst_seen;
	logic  after_reset;
	logic  done;
	int    cycles;

	mips_lite_core #(
		.RESET_PC(RESET_PC)
	) u_mips_lite_core (
		.clk       (clk),
		.rst_i     (rst_i),
		.wb_cyc_o  (wb_cyc_o),
		.wb_stb_o  (wb_stb_o),
		.wb_adr_o  (wb_adr_o),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_i  (wb_ack_i),
		.retire_o  (retire_o),
		.rd_we_o   (rd_we_o),
		.illegal_o (illegal_o),
		.rd_addr_o (rd_addr_o),
		.rd_data_o (rd_data_o)
	);

	tb_imem #(
		.BASE(RESET_PC)
	) u_imem (
		.clk        (clk),
		.wb_cyc_i   (wb_cyc_o),
		.wb_stb_i   (wb_stb_o),
		.wb_adr_i   (wb_adr_o),
		.wb_dat_o   (wb_dat_i),
		.wb_ack_o   (wb_ack_i),
		.prog_len_o (prog_len)
	);

	task automatic check_value(string name, word_t exp, word_t act);
		assert (exp === act) else begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_true(logic cond, string what);
		assert (cond) else begin
			$display("at %0t: %s", $time, what);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// reference behavior of one instruction on the model registers
	task automatic model_exec(input word_t ins, input word_t pc, output logic we,
			output reg_addr_t dst, output word_t val, output logic bad,
			output logic take, output word_t tgt);
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rt;
		logic [4:0] sh;
		word_t      a;
		word_t      b;
		word_t      simm;
		word_t      zimm;
		word_t      next_pc;
		op      = ins[31:26];
		fn      = ins[5:0];
		rt      = ins[20:16];
		sh      = ins[10:6];
		a       = mregs[ins[25:21]];
		b       = mregs[rt];
		simm    = {{16{ins[15]}}, ins[15:0]};
		zimm    = {16'h0, ins[15:0]};
		next_pc = pc + 4;
		we      = 1'b0;
		dst     = ins[15:11];
		val     = '0;
		bad     = 1'b0;
		take    = 1'b0;
		tgt     = next_pc + (simm << 2);
		case (op)
			OP_SPECIAL: begin
				we = 1'b1;
				case (fn)
					FN_SLL:  val = b << sh;
					FN_SRL:  val = b >> sh;
					FN_SRA:  val = $signed(b) >>> sh;
					FN_SLLV: val = b << a[4:0];
					FN_SRLV: val = b >> a[4:0];
					FN_SRAV: val = $signed(b) >>> a[4:0];
					FN_ADDU: val = a + b;
					FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_NOR:  val = ~(a | b);
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 1 : 0;
					FN_SLTU: val = (a < b) ? 1 : 0;
					FN_JR: begin
						we   = 1'b0;
						take = 1'b1;
						tgt  = a;
					end
					FN_JALR: begin
						val  = pc + 8;
						take = 1'b1;
						tgt  = a;
					end
					default: begin
						we  = 1'b0;
						bad = 1'b1;
					end
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				we  = 1'b1;
				dst = rt;
				case (op)
					OP_ANDI:  val = a & zimm;
					OP_ORI:   val = a | zimm;
					OP_XORI:  val = a ^ zimm;
					OP_LUI:   val = {ins[15:0], 16'h0};
					OP_ADDIU: val = a + simm;
					OP_SLTI:  val = ($signed(a) < $signed(simm)) ? 1 : 0;
					default:  val = (a < simm) ? 1 : 0;
				endcase
			end
			OP_J, OP_JAL: begin
				take = 1'b1;
				tgt  = {next_pc[31:28], ins[25:0], 2'b00};
				if (op == OP_JAL) begin
					we  = 1'b1;
					dst = 5'd31;
					val = pc + 8;
				end
			end
			OP_BEQ:  take = (a == b);
			OP_BNE:  take = (a != b);
			OP_BLEZ: take = ($signed(a) <= 0);
			OP_BGTZ: take = ($signed(a) > 0);
			OP_REGIMM: begin
				if (rt == RT_BLTZ) take = ($signed(a) < 0);
				else if (rt == RT_BGEZ) take = ($signed(a) >= 0);
				else bad = 1'b1;
			end
			default: bad = 1'b1;
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		void'($urandom(67310));
		rst_i       = 1'b1;
		done        = 1'b0;
		cycles      = 0;
		exp_pc      = RESET_PC;
		slot_active = 1'b0;
		in_flight   = 1'b0;
		held_valid  = 1'b0;
		rst_seen    = 1'b0;
		after_reset = 1'b0;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1 rst_i = 1'b0;
		wait (done);
		@(posedge clk);
		$display("No errors");
		$finish;
	end

	always @(posedge clk) begin
		logic      we;
		logic      bad;
		logic      take;
		reg_addr_t dst;
		word_t     val;
		word_t     tgt;
		cycles++;
		end_pc = RESET_PC + 32'(4 * prog_len);
		if (cycles > prog_len * 8 + 50) begin
			$display("Timeout: the program did not finish in %0d cycles", cycles);
			$display("Errors found");
			$fatal(1);
		end
		if (rst_i) begin
			// outputs are only defined once a reset edge has passed
			if (rst_seen) begin
				check_value("wb_cyc_o", 0, 32'(wb_cyc_o));
				check_value("retire_o", 0, 32'(retire_o));
			end
			rst_seen    = 1'b1;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				check_value("wb_cyc_o", 0, 32'(wb_cyc_o));
				check_value("retire_o", 0, 32'(retire_o));
				after_reset = 1'b0;
			end
			check_value("wb_stb_o", 32'(wb_cyc_o), 32'(wb_stb_o));
			check_true(retire_o || !rd_we_o, "rd_we_o high without a retire");
			if (held_valid) begin
				check_value("wb_stb_o", 1, 32'(wb_stb_o));
				check_value("wb_adr_o", held_adr, wb_adr_o);
			end
			held_valid = wb_cyc_o & wb_stb_o & ~wb_ack_i;
			held_adr   = wb_adr_o;
			if (wb_cyc_o && wb_ack_i) begin
				check_true(!in_flight, "second ack before the previous instruction retired");
				check_value("wb_adr_o", exp_pc, wb_adr_o);
				in_flight = 1'b1;
				cur_instr = wb_dat_i;
				cur_pc    = wb_adr_o;
			end else if (retire_o) begin
				check_true(in_flight, "retire without a fetched instruction");
				model_exec(cur_instr, cur_pc, we, dst, val, bad, take, tgt);
				check_value("illegal_o", 32'(bad), 32'(illegal_o));
				check_value("rd_we_o", 32'(we), 32'(rd_we_o));
				if (we) begin
					check_value("rd_addr_o", 32'(dst), 32'(rd_addr_o));
					check_value("rd_data_o", val, rd_data_o);
					if (dst != 0) mregs[dst] = val;
				end
				in_flight = 1'b0;
				// a branch in the delay slot is ignored
				if (slot_active) begin
					exp_pc      = saved_tgt;
					slot_active = 1'b0;
				end else begin
					exp_pc = cur_pc + 4;
					if (take) begin
						saved_tgt   = tgt;
						slot_active = 1'b1;
					end
				end
				if (exp_pc == end_pc) done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_imem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem #(
	parameter core_pkg::word_t BASE = 32'h0000_0040
) (
	input  logic            clk,
	input  logic            wb_cyc_i,
	input  logic            wb_stb_i,
	input  core_pkg::word_t wb_adr_i,
	output core_pkg::word_t wb_dat_o,
	output logic            wb_ack_o,
	output int              prog_len_o
);
	import core_pkg::*;
	import mips_isa_pkg::*;

	word_t mem [128];
	int    n;
	int    wait_cnt;
	logic  busy;
	logic  req;
	logic  acked;

	function automatic word_t enc_r(logic [5:0] fn, int rs, int rt, int rd, int sh);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic word_t enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t enc_j(logic [5:0] op, word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic word_t addr_of(int k);
		return BASE + 32'(4 * k);
	endfunction

	task automatic put(word_t w);
		mem[(BASE >> 2) + n] = w;
		n++;
	endtask

	initial begin
		wb_ack_o = 1'b0;
		wb_dat_o = '0;
		busy     = 1'b0;
		wait_cnt = 0;
		n        = 0;
		// undefined opcode tagged with the word's own address
		for (int i = 0; i < 128; i++) begin
			mem[i] = 32'hfc00_0000 | 32'(i << 2);
		end
		put(enc_i(OP_ORI, 0, 1, 16'h00ff));
		put(enc_i(OP_LUI, 0, 2, 16'h8000));
		put(enc_i(OP_ORI, 2, 2, 16'h1234));
		put(enc_i(OP_ANDI, 1, 3, 16'h0f0f));
		put(enc_i(OP_XORI, 1, 4, 16'hffff));
		put(enc_r(FN_AND, 1, 4, 5, 0));
		put(enc_r(FN_OR, 1, 2, 6, 0));
		put(enc_r(FN_XOR, 2, 4, 7, 0));
		put(enc_r(FN_NOR, 1, 2, 8, 0));
		put(enc_r(FN_SLL, 0, 1, 9, 4));
		put(enc_r(FN_SRL, 0, 2, 10, 8));
		put(enc_r(FN_SRA, 0, 2, 11, 8));
		put(enc_i(OP_ADDIU, 0, 12, 16'hfffd)); // k12 sets r12 to -3
		put(enc_r(FN_SLLV, 12, 1, 13, 0));
		put(enc_r(FN_SRLV, 12, 2, 14, 0));
		put(enc_r(FN_SRAV, 1, 2, 15, 0));
		put(enc_r(FN_ADDU, 1, 12, 16, 0));
		put(enc_r(FN_SUBU, 1, 2, 17, 0));
		put(enc_r(FN_SLT, 2, 1, 18, 0));
		put(enc_r(FN_SLTU, 2, 1, 19, 0));
		put(enc_i(OP_SLTI, 12, 20, 16'hfffe));
		put(enc_i(OP_SLTIU, 1, 21, 16'hffff));
		put(enc_i(OP_ADDIU, 1, 0, 16'h0005)); // write to r0
		put(enc_r(FN_ADDU, 0, 1, 22, 0));
		put(enc_i(OP_BEQ, 1, 1, 16'd2)); // k24 taken
		put(enc_i(OP_ADDIU, 0, 23, 16'd1));
		put(enc_i(OP_ADDIU, 0, 23, 16'd99));
		put(enc_i(OP_BNE, 1, 1, 16'd5)); // k27 not taken
		put(enc_i(OP_BGTZ, 1, 0, 16'd1));
		put(enc_i(OP_ORI, 0, 24, 16'd7));
		put(enc_i(OP_BLEZ, 12, 0, 16'd1)); // k30
		put(32'h0000_0000);
		put(enc_i(OP_REGIMM, 12, 32'(RT_BGEZ), 16'd3));
		put(enc_i(OP_REGIMM, 12, 32'(RT_BLTZ), 16'd1));
		put(enc_i(OP_ORI, 0, 25, 16'd5));
		put(enc_i(OP_BLEZ, 1, 0, 16'd4)); // k35 starts three not taken
		put(enc_i(OP_BGTZ, 12, 0, 16'd4));
		put(enc_i(OP_REGIMM, 1, 32'(RT_BLTZ), 16'd4));
		put(enc_i(OP_REGIMM, 1, 32'(RT_BGEZ), 16'd1));
		put(32'h0000_0000);
		put(enc_j(OP_JAL, addr_of(43))); // k40
		put(enc_i(OP_ORI, 0, 26, 16'd3));
		put(32'h0000_0000);
		put(enc_i(OP_ORI, 0, 27, 16'(addr_of(47))));
		put(enc_r(FN_JR, 27, 0, 0, 0));
		put(32'h0000_0000);
		put(enc_i(OP_ORI, 0, 28, 16'd1));
		put(enc_i(OP_ORI, 0, 29, 16'(addr_of(51)))); // k47
		put(enc_r(FN_JALR, 29, 0, 30, 0));
		put(32'h0000_0000);
		put(enc_i(OP_ORI, 0, 28, 16'd2));
		put(32'hfc00_0000); // k51 undefined opcode
		put(enc_i(OP_REGIMM, 1, 2, 16'd0)); // unknown regimm code
		put(enc_r(6'h3f, 1, 1, 1, 0));     // unknown funct
		put(enc_j(OP_J, addr_of(56)));
		put(32'h0000_0000);
		put(enc_r(FN_ADDU, 3, 31, 3, 0));
		prog_len_o = n;
	end

	// ack comes 1 ns after an edge following 0 to 3 wait cycles
	always @(posedge clk) begin
		req   = wb_cyc_i & wb_stb_i;
		acked = wb_ack_o;
		#1;
		if (acked) begin
			wb_ack_o = 1'b0;
			busy     = 1'b0;
		end else if (req) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = $urandom % 4;
			end
			if (wait_cnt == 0) begin
				wb_ack_o = 1'b1;
				wb_dat_o = mem[wb_adr_i[8:2]];
			end else begin
				wait_cnt--;
			end
		end
	end

endmodule

`default_nettype wire
